/* rtl/cfg_command_engine.sv */
`include "mcu_link_config.svh"

module cfg_command_engine import mcu_link_pkg::*; (
  input  logic        sys_clock,
  input  logic        reset,
  rx_link_if.receiver link,
  output logic        reply_valid,
  output link_byte_t  reply_data,
  input  logic        reply_credit,
  output logic        reg_write,
  output reg_addr_t   reg_addr,
  output link_byte_t  reg_wdata,
  input  link_byte_t  reg_rdata
);

  localparam int PTR_W = $clog2(`LINK_CREDITS);

  link_byte_t       buf_mem [`LINK_CREDITS];  // received bytes
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_count_t    buf_count;
  link_byte_t       head;
  logic             buf_empty;
  logic             pop;
  engine_state_t    state;
  reg_addr_t        addr_q;
  link_byte_t       reply_q;
  credit_count_t    reply_credits;  // free slots in the tx buffer

  assign head      = buf_mem[rd_ptr];
  assign buf_empty = buf_count == '0;
  // no pop while a reply waits for credit
  assign pop = !buf_empty && (state == st_idle || state == st_wdata);

  // write goes straight through from the buffer head
  assign reg_write   = state == st_wdata && !buf_empty;
  assign reg_wdata   = head;
  assign reg_addr    = (state == st_idle) ? head[2:0] : addr_q;  // read addr taken early
  assign reply_valid = state == st_reply;
  assign reply_data  = reply_q;

  always_ff @(posedge sys_clock) begin
    if (link.valid) begin
      buf_mem[wr_ptr] <= link.data;
    end
  end

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      buf_count   <= '0;
      link.credit <= 1'b0;
    end else begin
      if (link.valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      link.credit <= pop;  // one credit per consumed byte
      case ({link.valid, pop})
        2'b10:   buf_count <= buf_count + 1'b1;
        2'b01:   buf_count <= buf_count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  if (!buf_empty) state <= head[7] ? st_wdata : st_read;
        // data byte lost to a bad frame, drop the write
        st_wdata: if (!buf_empty || link.frame_error) state <= st_idle;
        st_read:  if (reply_credits != '0) state <= st_reply;
        st_reply: state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  // command payload
  always_ff @(posedge sys_clock) begin
    if (state == st_idle && !buf_empty) begin
      addr_q <= head[2:0];
      if (!head[7]) reply_q <= reg_rdata;  // read value, one cycle after valid
    end
  end

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      reply_credits <= credit_count_t'(`LINK_CREDITS);
    end else begin
      case ({reply_valid, reply_credit})
        2'b10:   reply_credits <= reply_credits - 1'b1;
        2'b01:   reply_credits <= reply_credits + 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* rtl/cfg_register_file.sv */
`include "mcu_link_config.svh"

module cfg_register_file import mcu_link_pkg::*; (
  input  logic        sys_clock,
  input  logic        reset,
  input  logic        reg_write,
  input  reg_addr_t   reg_addr,
  input  link_byte_t  reg_wdata,
  output link_byte_t  reg_rdata,
  input  logic        frame_error_seen,
  input  chip_model_t chip_ext,
  input  logic        standard_sw,
  output chip_model_t chip,
  output logic        standard
);

  localparam int        RW_REGS     = `LINK_REG_COUNT - 1;  // status slot is last
  localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`LINK_STATUS_ADDR);
  localparam int        CHIP_REG    = 0;
  localparam int        STD_REG     = 1;

  link_byte_t regs [RW_REGS];
  link_byte_t frame_err_count;

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      for (int i = 0; i < RW_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && reg_addr != STATUS_ADDR) begin  // status is read-only
      regs[reg_addr] <= reg_wdata;
    end
  end

  // bad stop bits seen, sticks at 255
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      frame_err_count <= '0;
    end else if (frame_error_seen && frame_err_count != 8'hff) begin
      frame_err_count <= frame_err_count + 8'd1;
    end
  end

  always_comb begin
    if (reg_addr == STATUS_ADDR) begin
      reg_rdata = frame_err_count;
    end else begin
      reg_rdata = regs[reg_addr];
    end
  end

  // bit 7 of reg 0 picks the override over the pins
  assign chip = regs[CHIP_REG][7] ? regs[CHIP_REG][1:0] : chip_ext;

  // reg 1 bit 0 flips the switch
  assign standard = standard_sw ^ regs[STD_REG][0];

endmodule

/* rtl/mcu_link_config.svh */
`ifndef MCU_LINK_CONFIG_SVH
`define MCU_LINK_CONFIG_SVH

// serial bit timing in sys_clock cycles per bit
// the receiver start wait needs 4 or more
`define LINK_CLKS_PER_BIT 8

// entries in each receiving buffer and so the starting credit count
`define LINK_CREDITS 2

// size of the register block
`define LINK_REG_COUNT 8

// read-only framing error counter lives here
`define LINK_STATUS_ADDR 7

`endif

/* rtl/mcu_link_pkg.sv */
package mcu_link_pkg;

  // one byte on the serial line
  typedef logic [7:0] link_byte_t;

  // config register address, bits 2:0 of a command byte
  typedef logic [2:0] reg_addr_t;

  // chip model code, same encoding as the chip_ext pins
  typedef logic [1:0] chip_model_t;

  // credit counter, holds 0 up to the buffer depth
  typedef logic [1:0] credit_count_t;

  // command engine states
  typedef enum logic [1:0] {
    st_idle,   // waiting for a command byte
    st_wdata,  // write command seen, waiting for data
    st_read,   // read value held, waiting for reply credit
    st_reply   // reply byte handed to the transmitter
  } engine_state_t;

endpackage

/* rtl/mcu_link_top.sv */
module mcu_link_top import mcu_link_pkg::*; (
  input  logic       sys_clock,
  input  logic       reset,
  input  logic       rx,
  input  logic       standard_sw,
  input  logic [1:0] chip_ext,
  output logic       tx,
  output logic       standard,
  output logic [1:0] chip
);

  rx_link_if rx_link ();

  logic       reply_valid;
  link_byte_t reply_data;
  logic       reply_credit;     // tx buffer slot freed
  logic       reg_write;
  reg_addr_t  reg_addr;
  link_byte_t reg_wdata;
  link_byte_t reg_rdata;
  logic       frame_error_seen;

  serial_rx rx_i (
    .sys_clock        (sys_clock),
    .reset            (reset),
    .rx               (rx),
    .link             (rx_link),
    .frame_error_seen (frame_error_seen)
  );

  cfg_command_engine engine_i (
    .sys_clock    (sys_clock),
    .reset        (reset),
    .link         (rx_link),
    .reply_valid  (reply_valid),
    .reply_data   (reply_data),
    .reply_credit (reply_credit),
    .reg_write    (reg_write),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata)
  );

  cfg_register_file regs_i (
    .sys_clock        (sys_clock),
    .reset            (reset),
    .reg_write        (reg_write),
    .reg_addr         (reg_addr),
    .reg_wdata        (reg_wdata),
    .reg_rdata        (reg_rdata),
    .frame_error_seen (frame_error_seen),
    .chip_ext         (chip_ext),
    .standard_sw      (standard_sw),
    .chip             (chip),
    .standard         (standard)
  );

  serial_tx tx_i (
    .sys_clock    (sys_clock),
    .reset        (reset),
    .reply_valid  (reply_valid),
    .reply_data   (reply_data),
    .reply_credit (reply_credit),
    .tx           (tx)
  );

endmodule

/* rtl/rx_link_if.sv */
interface rx_link_if import mcu_link_pkg::*; ();

  logic       valid;        // byte presented, one cycle
  link_byte_t data;         // received byte
  logic       frame_error;  // stop bit was 0, byte dropped
  logic       credit;       // one buffer entry freed by the engine

  modport sender (
    output valid,
    output data,
    output frame_error,
    input  credit
  );

  modport receiver (
    input  valid,
    input  data,
    input  frame_error,
    output credit
  );

endinterface

/* rtl/serial_rx.sv */
`include "mcu_link_config.svh"

module serial_rx import mcu_link_pkg::*; (
  input  logic      sys_clock,
  input  logic      reset,
  input  logic      rx,
  rx_link_if.sender link,
  output logic      frame_error_seen
);

  localparam int CNT_W = $clog2(`LINK_CLKS_PER_BIT);
  // half a bit less the two synchronizer stages
  localparam int START_WAIT = `LINK_CLKS_PER_BIT / 2 - 2;

  logic          rx_meta;
  logic          rx_line;     // synchronized line
  logic          busy;
  logic [CNT_W-1:0] tick_cnt;
  logic [3:0]    bit_idx;     // 0 start, 1..8 data, 9 stop
  link_byte_t    shift_q;
  credit_count_t credits;
  logic          frame_error_q;
  logic          sample;
  logic          stop_done;

  assign sample    = busy && tick_cnt == '0;  // mid-bit point
  assign stop_done = sample && bit_idx == 4'd9;

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      rx_meta <= 1'b1;  // line idles high
      rx_line <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_line <= rx_meta;
    end
  end

  // bit timing
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      busy     <= 1'b0;
      tick_cnt <= '0;
      bit_idx  <= '0;
    end else if (!busy) begin
      if (!rx_line) begin  // falling edge of start bit
        busy     <= 1'b1;
        tick_cnt <= CNT_W'(START_WAIT);
        bit_idx  <= '0;
      end
    end else if (sample) begin
      tick_cnt <= CNT_W'(`LINK_CLKS_PER_BIT - 1);
      bit_idx  <= bit_idx + 4'd1;
      // a start bit gone high by mid-bit was a glitch
      if ((bit_idx == 4'd0 && rx_line) || bit_idx == 4'd9) begin
        busy <= 1'b0;
      end
    end else begin
      tick_cnt <= tick_cnt - 1'b1;
    end
  end

  always_ff @(posedge sys_clock) begin
    if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
      shift_q <= {rx_line, shift_q[7:1]};  // lsb arrives first
    end
  end

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      link.valid    <= 1'b0;
      frame_error_q <= 1'b0;
    end else begin
      link.valid    <= stop_done && rx_line && credits != '0;
      frame_error_q <= stop_done && !rx_line;
    end
  end

  assign link.data        = shift_q;  // held until the next data bit
  assign link.frame_error = frame_error_q;
  assign frame_error_seen = frame_error_q;

  // credits owed by the engine buffer
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      credits <= credit_count_t'(`LINK_CREDITS);
    end else begin
      case ({link.valid, link.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  // engine must have drained a slot before the next good stop bit
  a_rx_credit: assert property (@(posedge sys_clock) disable iff (reset)
    (stop_done && rx_line) |-> credits != '0)
    else $error("serial_rx: byte completed with no credit");

endmodule

/* rtl/serial_tx.sv */
`include "mcu_link_config.svh"

module serial_tx import mcu_link_pkg::*; (
  input  logic       sys_clock,
  input  logic       reset,
  input  logic       reply_valid,
  input  link_byte_t reply_data,
  output logic       reply_credit,
  output logic       tx
);

  localparam int CNT_W = $clog2(`LINK_CLKS_PER_BIT);
  localparam int PTR_W = $clog2(`LINK_CREDITS);

  link_byte_t       fifo_mem [`LINK_CREDITS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_count_t    fifo_count;
  logic             busy;
  logic [CNT_W-1:0] tick_cnt;
  logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
  link_byte_t       shift_q;
  logic             pop;
  logic             bit_end;

  assign pop     = !busy && fifo_count != '0;  // shifter idle, entry waiting
  assign bit_end = busy && tick_cnt == '0;

  always_ff @(posedge sys_clock) begin
    if (reply_valid) begin
      fifo_mem[wr_ptr] <= reply_data;
    end
  end

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (reply_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({reply_valid, pop})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: ;
      endcase
    end
  end

  // shifter, start bit goes out right after the pop
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      busy         <= 1'b0;
      tx           <= 1'b1;
      tick_cnt     <= '0;
      bit_idx      <= '0;
      reply_credit <= 1'b0;
    end else begin
      reply_credit <= pop;  // slot freed, hand credit back
      if (pop) begin
        busy     <= 1'b1;
        tx       <= 1'b0;
        tick_cnt <= CNT_W'(`LINK_CLKS_PER_BIT - 1);
        bit_idx  <= '0;
      end else if (bit_end) begin
        tick_cnt <= CNT_W'(`LINK_CLKS_PER_BIT - 1);
        bit_idx  <= bit_idx + 4'd1;
        if (bit_idx == 4'd9) busy <= 1'b0;  // stop bit fully sent
        else tx <= shift_q[0];
      end else if (busy) begin
        tick_cnt <= tick_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clock) begin
    if (pop) shift_q <= fifo_mem[rd_ptr];
    else if (bit_end) shift_q <= {1'b1, shift_q[7:1]};  // ones fill in the stop bit
  end

  a_tx_no_overflow: assert property (@(posedge sys_clock) disable iff (reset)
    reply_valid |-> fifo_count != credit_count_t'(`LINK_CREDITS))
    else $error("serial_tx: reply pushed into full buffer");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and pass only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mcu_link -f verilog.f \
  && ./obj_dir/Vtb_mcu_link | tee /dev/stderr | grep -qx "All tests passed" \
  && echo "simulation run: PASS" \
  || { echo "simulation run: FAIL"; exit 1; }

/* tests/tb_mcu_link.sv */
`include "mcu_link_config.svh"

module tb_mcu_link import mcu_link_pkg::*; ();

  localparam int REPLY_TIMEOUT = 40 * `LINK_CLKS_PER_BIT;  // cycles to wait for a start bit

  typedef enum {k_write, k_write_rand, k_read, k_pins, k_bad, k_burst} row_kind_t;

  logic        sys_clock;
  logic        reset;
  logic        rx;
  logic        standard_sw;
  chip_model_t chip_ext;
  logic        tx;
  logic        standard;
  chip_model_t chip;

  // stimulus table, one entry per test
  string       row_name [$];
  row_kind_t   row_kind [$];
  reg_addr_t   row_addr [$];
  link_byte_t  row_data [$];
  chip_model_t row_pins [$];
  logic        row_sw [$];
  logic [2:0]  row_exp [$];  // {standard, chip} for pin rows

  link_byte_t  shadow [8];   // expected register contents
  logic [31:0] rng_state;
  int          test_errors;
  int          failed_tests;

  mcu_link_top dut_i (
    .sys_clock   (sys_clock),
    .reset       (reset),
    .rx          (rx),
    .standard_sw (standard_sw),
    .chip_ext    (chip_ext),
    .tx          (tx),
    .standard    (standard),
    .chip        (chip)
  );

  initial begin
    sys_clock = 1'b0;
    forever #20 sys_clock = ~sys_clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic void add_row(input string name, input row_kind_t kind, input reg_addr_t addr,
                                  input link_byte_t data, input chip_model_t pins,
                                  input logic sw, input logic [2:0] exp);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_pins.push_back(pins);
    row_sw.push_back(sw);
    row_exp.push_back(exp);
  endfunction

  // start, 8 data bits lsb first, stop
  task automatic send_byte(input link_byte_t b, input logic bad_stop);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge sys_clock);
      rx <= frame[i];
      if (i == 9 && bad_stop) begin
        rx <= 1'b0;
        repeat (`LINK_CLKS_PER_BIT / 2) @(posedge sys_clock);
        rx <= 1'b1;  // low stop only half a bit, line idle before the next sample
        repeat (`LINK_CLKS_PER_BIT / 2 - 1) @(posedge sys_clock);
      end else begin
        repeat (`LINK_CLKS_PER_BIT - 1) @(posedge sys_clock);
      end
    end
  endtask

  task automatic recv_byte(input string name, output link_byte_t b, output logic ok);
    int waited;
    waited = 0;
    b = '0;
    ok = 1'b0;
    @(negedge sys_clock);
    while (tx !== 1'b0 && waited < REPLY_TIMEOUT) begin
      @(negedge sys_clock);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("%s: no reply start bit on tx within %0d cycles", name, REPLY_TIMEOUT);
      return;
    end
    repeat (`LINK_CLKS_PER_BIT / 2) @(negedge sys_clock);  // middle of start bit
    for (int i = 0; i < 8; i++) begin
      repeat (`LINK_CLKS_PER_BIT) @(negedge sys_clock);
      b = {tx, b[7:1]};
    end
    repeat (`LINK_CLKS_PER_BIT) @(negedge sys_clock);
    if (tx !== 1'b1) $display("%s: reply stop bit on tx was low", name);
    else ok = 1'b1;
  endtask

  task automatic read_reg(input string name, input reg_addr_t addr, output link_byte_t b);
    logic       ok;
    link_byte_t got;
    fork
      send_byte({5'b00000, addr}, 1'b0);  // bit 7 clear, read
      recv_byte(name, got, ok);
    join
    if (!ok) test_errors++;
    b = got;
  endtask

  task automatic expect_tx_idle(input string name, input int cycles);
    logic seen_start;
    seen_start = 1'b0;
    repeat (cycles) begin
      @(negedge sys_clock);
      if (tx !== 1'b1) seen_start = 1'b1;
    end
    if (seen_start) begin
      $display("%s: tx sent a byte although no reply was due", name);
      test_errors++;
    end
  endtask

  task automatic check_byte(input string name, input link_byte_t exp, input link_byte_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %02h, got %02h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_chip(input string name, input chip_model_t exp, input chip_model_t act);
    if (act !== exp) begin
      $display("ERR %s: chip expected %0d, got %0d", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: standard expected %b, got %b", name, exp, act);
      test_errors++;
    end
  endtask

  initial begin
    link_byte_t wdata;
    link_byte_t rdata;
    link_byte_t burst_got [6];
    logic       ok;
    rx          <= 1'b1;
    chip_ext    <= 2'd0;
    standard_sw <= 1'b0;
    reset       <= 1'b1;
    rng_state = 32'he95b_9c27;
    failed_tests = 0;
    for (int i = 0; i < 8; i++) shadow[i] = 8'h00;
    for (int i = 0; i < 7; i++) begin
      add_row($sformatf("write_rand_r%0d", i), k_write_rand, reg_addr_t'(i), 8'h00, 2'd0, 1'b0,
              3'b000);
    end
    for (int i = 0; i < 7; i++) begin
      add_row($sformatf("read_r%0d", i), k_read, reg_addr_t'(i), 8'h00, 2'd0, 1'b0, 3'b000);
    end
    add_row("chip_from_pins", k_write, 3'd0, 8'h00, 2'd0, 1'b0, 3'b000);
    add_row("std_plain", k_write, 3'd1, 8'h00, 2'd0, 1'b0, 3'b000);
    add_row("pins_chip0", k_pins, 3'd0, 8'h00, 2'd0, 1'b0, 3'b000);
    add_row("pins_chip1", k_pins, 3'd0, 8'h00, 2'd1, 1'b1, 3'b101);
    add_row("pins_chip2", k_pins, 3'd0, 8'h00, 2'd2, 1'b0, 3'b010);
    add_row("pins_chip3", k_pins, 3'd0, 8'h00, 2'd3, 1'b1, 3'b111);
    add_row("chip_override_2", k_write, 3'd0, 8'h82, 2'd0, 1'b0, 3'b000);
    add_row("override_pins0", k_pins, 3'd0, 8'h00, 2'd0, 1'b0, 3'b010);
    add_row("override_pins3", k_pins, 3'd0, 8'h00, 2'd3, 1'b1, 3'b110);
    add_row("std_inverted", k_write, 3'd1, 8'h01, 2'd0, 1'b0, 3'b000);
    add_row("invert_sw0", k_pins, 3'd0, 8'h00, 2'd1, 1'b0, 3'b110);
    add_row("invert_sw1", k_pins, 3'd0, 8'h00, 2'd2, 1'b1, 3'b010);
    add_row("chip_override_1", k_write, 3'd0, 8'h81, 2'd0, 1'b0, 3'b000);
    add_row("override_pins2", k_pins, 3'd0, 8'h00, 2'd2, 1'b0, 3'b101);
    add_row("read_burst", k_burst, 3'd0, 8'h00, 2'd0, 1'b0, 3'b000);
    add_row("bad_frames", k_bad, 3'd3, 8'h5a, 2'd0, 1'b0, 3'b000);
    add_row("read_r3_after_bad", k_read, 3'd3, 8'h00, 2'd0, 1'b0, 3'b000);
    add_row("read_error_count", k_read, 3'd7, 8'h00, 2'd0, 1'b0, 3'b000);
    add_row("write_status", k_write, 3'd7, 8'h33, 2'd0, 1'b0, 3'b000);
    add_row("read_status_kept", k_read, 3'd7, 8'h00, 2'd0, 1'b0, 3'b000);

    repeat (5) @(posedge sys_clock);
    reset <= 1'b0;
    repeat (4) @(posedge sys_clock);

    for (int r = 0; r < row_name.size(); r++) begin
      test_errors = 0;
      case (row_kind[r])
        k_write, k_write_rand: begin
          wdata = row_data[r];
          if (row_kind[r] == k_write_rand) begin
            rng_state = xorshift32(rng_state);
            wdata = rng_state[7:0];
          end
          send_byte({5'b10000, row_addr[r]}, 1'b0);  // bit 7 set, write
          send_byte(wdata, 1'b0);
          repeat (2) @(posedge sys_clock);  // lands one cycle after the data valid
          if (row_addr[r] != reg_addr_t'(`LINK_STATUS_ADDR)) shadow[row_addr[r]] = wdata;
        end
        k_read: begin
          read_reg(row_name[r], row_addr[r], rdata);
          check_byte(row_name[r], shadow[row_addr[r]], rdata);
        end
        k_pins: begin
          @(posedge sys_clock);
          chip_ext    <= row_pins[r];
          standard_sw <= row_sw[r];
          @(negedge sys_clock);  // steering is combinational
          check_chip(row_name[r], row_exp[r][1:0], chip);
          check_bit(row_name[r], row_exp[r][2], standard);
        end
        k_bad: begin
          fork
            begin
              send_byte({5'b10000, row_addr[r]}, 1'b1);
              send_byte(row_data[r], 1'b1);
            end
            expect_tx_idle(row_name[r], 30 * `LINK_CLKS_PER_BIT);
          join
          shadow[`LINK_STATUS_ADDR] = shadow[`LINK_STATUS_ADDR] + 8'd2;
        end
        k_burst: begin
          // six reads with no gap, replies must come back in order
          fork
            begin
              for (int i = 0; i < 6; i++) send_byte({5'b00000, reg_addr_t'(i)}, 1'b0);
            end
            begin
              for (int i = 0; i < 6; i++) begin
                recv_byte(row_name[r], burst_got[i], ok);
                if (!ok) test_errors++;
              end
            end
          join
          for (int i = 0; i < 6; i++) check_byte(row_name[r], shadow[i], burst_got[i]);
        end
        default: ;
      endcase
      if (test_errors == 0) begin
        $display("test %s ok", row_name[r]);
      end else begin
        $display("test %s failed with %0d errors", row_name[r], test_errors);
        failed_tests++;
      end
    end

    $display("%0d tests run, %0d with errors", row_name.size(), failed_tests);
    if (failed_tests == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/mcu_link_pkg.sv
rtl/rx_link_if.sv
rtl/serial_rx.sv
rtl/serial_tx.sv
rtl/cfg_command_engine.sv
rtl/cfg_register_file.sv
rtl/mcu_link_top.sv
tests/tb_mcu_link.sv
